// ==== rtl/ptw_pkg.sv ====
package ptw_pkg;

    // Bus and address widths
    localparam int PTE_W    = 64;
    localparam int PPN_W    = 44;
    localparam int VA_W     = 39;
    localparam int PA_W     = 56;

    // One VPN slice indexes a 512 entry table
    localparam int VPN_W    = 9;
    localparam int PG_OFF_W = 12;

    // Table level that also serves as page size at the leaf
    localparam int LVL_W    = 2;

    localparam logic [LVL_W-1:0] LVL_1G = 2'd0;
    localparam logic [LVL_W-1:0] LVL_2M = 2'd1;
    localparam logic [LVL_W-1:0] LVL_4K = 2'd2;

    // PTE flag positions
    localparam int PTE_V     = 0;
    localparam int PTE_R     = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X     = 3;
    localparam int PTE_U     = 4;
    localparam int PTE_G     = 5;
    localparam int PTE_A     = 6;
    localparam int PTE_D     = 7;

    // PPN sits between the flags and the reserved top bits
    localparam int PTE_PPN_LSB  = 10;
    localparam int PTE_RSVD_LSB = 54;

    // Fault cause codes
    localparam int CAUSE_W = 12;

    localparam logic [CAUSE_W-1:0] LOAD_PAGE_FAULT    = 12'd13;
    localparam logic [CAUSE_W-1:0] STORE_PAGE_FAULT   = 12'd15;
    // Memory returned an error on a PTE read
    localparam logic [CAUSE_W-1:0] PT_DATA_CORRUPTION = 12'd274;

endpackage

// ==== rtl/pte_if.sv ====
`timescale 1ns/1ps

interface pte_if
    import ptw_pkg::*;
();

    // Fetched PTE under evaluation
    logic [PTE_W-1:0]         pte;
    // Level the PTE was read from
    logic [LVL_W-1:0]         level;
    // All three VPN slices of the registered IOVA
    logic [VA_W-PG_OFF_W-1:0] vpn;
    // Access type of the walk
    logic                     is_store;

    // Walk controller side
    modport ctrl (
        output pte,
        output level,
        output vpn,
        output is_store
    );

    // PTE checker and address generator side
    modport eval (
        input  pte,
        input  level,
        input  vpn,
        input  is_store
    );

endinterface

// ==== rtl/pte_checker.sv ====
`timescale 1ns/1ps

module pte_checker
    import ptw_pkg::*;
(
    pte_if.eval  pte_i,
    output logic is_leaf_o,
    output logic pte_fault_o
);

    // PTE flags
    logic v_bit;
    logic r_bit;
    logic w_bit;
    logic x_bit;
    logic u_bit;
    logic a_bit;
    logic d_bit;

    logic [PPN_W-1:0] ppn;

    // Individual fault rules
    logic invalid;
    logic rsvd_set;
    logic misaligned;
    logic ptr_fault;
    logic leaf_fault;

    assign v_bit = pte_i.pte[PTE_V];
    assign r_bit = pte_i.pte[PTE_R];
    assign w_bit = pte_i.pte[PTE_W_BIT];
    assign x_bit = pte_i.pte[PTE_X];
    assign u_bit = pte_i.pte[PTE_U];
    assign a_bit = pte_i.pte[PTE_A];
    assign d_bit = pte_i.pte[PTE_D];

    assign ppn = pte_i.pte[PTE_RSVD_LSB-1:PTE_PPN_LSB];

    // Leaf as soon as any of R or X is set
    assign is_leaf_o = r_bit | x_bit;

    // Not valid or writable without being readable
    assign invalid = ~v_bit | (~r_bit & w_bit);

    // Top bits are reserved and must read as zero
    assign rsvd_set = |pte_i.pte[PTE_W-1:PTE_RSVD_LSB];

    // Superpage PPN must be aligned to its own size
    always_comb begin
        case (pte_i.level)
            LVL_1G:  misaligned = |ppn[2*VPN_W-1:0];
            LVL_2M:  misaligned = |ppn[VPN_W-1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Pointer needs A, D and U clear and cannot sit at the last level
    assign ptr_fault = a_bit | d_bit | u_bit | (pte_i.level == LVL_4K);

    // Leaf needs A and R, plus D when the access is a store
    assign leaf_fault = misaligned | ~a_bit | ~r_bit | (pte_i.is_store & ~d_bit);

    assign pte_fault_o = invalid | rsvd_set | (is_leaf_o ? leaf_fault : ptr_fault);

endmodule

// ==== rtl/next_addr_gen.sv ====
`timescale 1ns/1ps

module next_addr_gen
    import ptw_pkg::*;
(
    pte_if.eval              pte_i,
    output logic [PA_W-1:0]  next_addr_o,
    output logic [PA_W-1:0]  leaf_paddr_o
);

    logic [PPN_W-1:0] ppn;
    // VPN slice that indexes the next table
    logic [VPN_W-1:0] vpn_next;
    // PPN with the superpage bits taken from the VPN
    logic [PPN_W-1:0] leaf_ppn;

    assign ppn = pte_i.pte[PTE_RSVD_LSB-1:PTE_PPN_LSB];

    // Level 1 points to a 2M table, level 2 to a 4K table
    always_comb begin
        case (pte_i.level)
            LVL_1G:  vpn_next = pte_i.vpn[VPN_W +: VPN_W];
            default: vpn_next = pte_i.vpn[0 +: VPN_W];
        endcase
    end

    // Table base plus 8 byte entry index
    assign next_addr_o = {ppn, vpn_next, 3'b000};

    always_comb begin
        leaf_ppn = ppn;
        case (pte_i.level)
            // 1G page keeps VPN[1] and VPN[0]
            LVL_1G: begin
                leaf_ppn[2*VPN_W-1:0] = pte_i.vpn[2*VPN_W-1:0];
            end
            // 2M page keeps VPN[0]
            LVL_2M: begin
                leaf_ppn[VPN_W-1:0] = pte_i.vpn[VPN_W-1:0];
            end
            default: begin
                leaf_ppn = ppn;
            end
        endcase
    end

    // Page offset is filled in by the controller
    assign leaf_paddr_o = {leaf_ppn, {PG_OFF_W{1'b0}}};

endmodule

// ==== rtl/walk_ctrl.sv ====
`timescale 1ns/1ps

module walk_ctrl
    import ptw_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,

    // Walk request handshake
    input  logic               walk_req_i,
    output logic               walk_ack_o,
    input  logic [VA_W-1:0]    iova_i,
    input  logic               is_store_i,
    input  logic [PPN_W-1:0]   root_ppn_i,

    // PTE read handshake
    output logic               mem_req_o,
    output logic [PA_W-1:0]    mem_addr_o,
    input  logic               mem_ack_i,
    input  logic [PTE_W-1:0]   mem_rdata_i,
    input  logic               mem_err_i,

    // PTE and context to the evaluators
    pte_if.ctrl                pte_o,

    // Evaluator results
    input  logic               is_leaf_i,
    input  logic               pte_fault_i,
    input  logic [PA_W-1:0]    next_addr_i,
    input  logic [PA_W-1:0]    leaf_paddr_i,

    // Walk result
    output logic               fault_o,
    output logic [CAUSE_W-1:0] cause_o,
    output logic [PA_W-1:0]    paddr_o,
    output logic [LVL_W-1:0]   page_size_o,
    output logic               global_o
);

    typedef enum logic [2:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT_LOW,
        EVAL,
        DONE
    } state_e;

    state_e state_q;

    // Control registers
    logic [LVL_W-1:0]   level_q;
    logic               global_q;
    logic               fault_q;

    // Walk payload
    logic [VA_W-1:0]    iova_q;
    logic               is_store_q;
    logic [PA_W-1:0]    addr_q;
    logic [PTE_W-1:0]   pte_q;
    logic               err_q;
    logic [CAUSE_W-1:0] cause_q;
    logic [PA_W-1:0]    paddr_q;
    logic [LVL_W-1:0]   size_q;

    // EVAL outcome
    logic               walk_fault;
    logic               walk_leaf;
    logic [CAUSE_W-1:0] cause_n;

    // Memory error wins over any PTE rule
    assign walk_fault = err_q | pte_fault_i;
    assign walk_leaf  = ~walk_fault & is_leaf_i;

    always_comb begin
        if (err_q) begin
            cause_n = PT_DATA_CORRUPTION;
        end else if (is_store_q) begin
            cause_n = STORE_PAGE_FAULT;
        end else begin
            cause_n = LOAD_PAGE_FAULT;
        end
    end

    // State, level and result flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            level_q  <= LVL_1G;
            global_q <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (walk_req_i) begin
                        state_q  <= MEM_REQ;
                        level_q  <= LVL_1G;
                        global_q <= 1'b0;
                        fault_q  <= 1'b0;
                    end
                end
                MEM_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= MEM_WAIT_LOW;
                    end
                end
                // Memory must release its ack before the PTE is used
                MEM_WAIT_LOW: begin
                    if (!mem_ack_i) begin
                        state_q <= EVAL;
                    end
                end
                EVAL: begin
                    // G bit only counts when the read succeeded
                    if (!err_q) begin
                        global_q <= global_q | pte_q[PTE_G];
                    end
                    if (walk_fault || walk_leaf) begin
                        state_q <= DONE;
                        fault_q <= walk_fault;
                    end else begin
                        state_q <= MEM_REQ;
                        level_q <= level_q + LVL_W'(1);
                    end
                end
                // Hold the result until the requester lets go
                DONE: begin
                    if (!walk_req_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request context, fetched PTE and result data
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && walk_req_i) begin
            iova_q     <= iova_i;
            is_store_q <= is_store_i;
            // Level 1 entry indexed by VPN[2]
            addr_q     <= {root_ppn_i, iova_i[VA_W-1:PG_OFF_W+2*VPN_W], 3'b000};
        end
        if (state_q == MEM_REQ && mem_ack_i) begin
            pte_q <= mem_rdata_i;
            err_q <= mem_err_i;
        end
        if (state_q == EVAL) begin
            addr_q  <= next_addr_i;
            cause_q <= cause_n;
            size_q  <= level_q;
            if (walk_leaf) begin
                paddr_q <= leaf_paddr_i | {{(PA_W-PG_OFF_W){1'b0}}, iova_q[PG_OFF_W-1:0]};
            end else begin
                paddr_q <= '0;
            end
        end
    end

    assign pte_o.pte      = pte_q;
    assign pte_o.level    = level_q;
    assign pte_o.vpn      = iova_q[VA_W-1:PG_OFF_W];
    assign pte_o.is_store = is_store_q;

    assign mem_req_o  = (state_q == MEM_REQ);
    assign mem_addr_o = addr_q;
    assign walk_ack_o = (state_q == DONE);

    assign fault_o     = fault_q;
    assign cause_o     = cause_q;
    assign paddr_o     = paddr_q;
    assign page_size_o = size_q;
    assign global_o    = global_q;

endmodule

// ==== rtl/ptw_top.sv ====
`timescale 1ns/1ps

module ptw_top
    import ptw_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,

    // Walk request and result
    input  logic               walk_req_i,
    output logic               walk_ack_o,
    input  logic [VA_W-1:0]    iova_i,
    input  logic               is_store_i,
    input  logic [PPN_W-1:0]   root_ppn_i,

    // PTE memory read port
    output logic               mem_req_o,
    output logic [PA_W-1:0]    mem_addr_o,
    input  logic               mem_ack_i,
    input  logic [PTE_W-1:0]   mem_rdata_i,
    input  logic               mem_err_i,

    output logic               fault_o,
    output logic [CAUSE_W-1:0] cause_o,
    output logic [PA_W-1:0]    paddr_o,
    output logic [LVL_W-1:0]   page_size_o,
    output logic               global_o
);

    // Evaluator results back to the controller
    logic            is_leaf;
    logic            pte_fault;
    logic [PA_W-1:0] next_addr;
    logic [PA_W-1:0] leaf_paddr;

    // Fetched PTE shared by both evaluators
    pte_if u_pte_if ();

    walk_ctrl u_walk_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_req_i   (walk_req_i),
        .walk_ack_o   (walk_ack_o),
        .iova_i       (iova_i),
        .is_store_i   (is_store_i),
        .root_ppn_i   (root_ppn_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_err_i    (mem_err_i),
        .pte_o        (u_pte_if.ctrl),
        .is_leaf_i    (is_leaf),
        .pte_fault_i  (pte_fault),
        .next_addr_i  (next_addr),
        .leaf_paddr_i (leaf_paddr),
        .fault_o      (fault_o),
        .cause_o      (cause_o),
        .paddr_o      (paddr_o),
        .page_size_o  (page_size_o),
        .global_o     (global_o)
    );

    pte_checker u_pte_checker (
        .pte_i       (u_pte_if.eval),
        .is_leaf_o   (is_leaf),
        .pte_fault_o (pte_fault)
    );

    next_addr_gen u_next_addr_gen (
        .pte_i        (u_pte_if.eval),
        .next_addr_o  (next_addr),
        .leaf_paddr_o (leaf_paddr)
    );

endmodule

// ==== test/tb_ptw_ref.svh ====
`ifndef TB_PTW_REF_SVH
`define TB_PTW_REF_SVH

// Next value of the 32 bit LCG shared by all random choices
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Sv39 PTE layout with reserved top bits, PPN, two software bits and flags
function automatic logic [PTE_W-1:0] make_pte(input logic [PPN_W-1:0] ppn,
                                              input logic [7:0] flags);
    return {10'b0, ppn, 2'b00, flags};
endfunction

// VPN slice idx of an IOVA where slice 2 is the top one
function automatic logic [VPN_W-1:0] vpn_slice(input logic [VA_W-1:0] iova, input int idx);
    return iova[PG_OFF_W + VPN_W * idx +: VPN_W];
endfunction

// Fresh table chain from the root down to a leaf at leaf_lvl
function automatic void build_walk(input logic [VA_W-1:0] iova, input logic [PPN_W-1:0] root,
                                   input int leaf_lvl, input logic [7:0] leaf_flags,
                                   input logic [PPN_W-1:0] leaf_ppn, input logic ptr_g);
    logic [PPN_W-1:0] tbl;
    logic [7:0]       ptr_flags;
    mem.delete();
    err_set.delete();
    tbl = root;
    ptr_flags = ptr_g ? (F_V | F_G) : F_V;
    for (int l = 0; l <= leaf_lvl; l++) begin
        ent_addr[l] = {tbl, vpn_slice(iova, 2 - l), 3'b000};
        if (l == leaf_lvl) begin
            mem[ent_addr[l]] = make_pte(leaf_ppn, leaf_flags);
        end else begin
            // Each lower table gets its own page next to the root
            mem[ent_addr[l]] = make_pte(root + PPN_W'(l + 1), ptr_flags);
            tbl = root + PPN_W'(l + 1);
        end
    end
endfunction

// Expected walk straight from the Sv39 rules kept by the design
function automatic void ref_walk(input logic [VA_W-1:0] iova, input logic store,
                                 input logic [PPN_W-1:0] root, output logic fault,
                                 output logic [CAUSE_W-1:0] cause, output logic [PA_W-1:0] pa,
                                 output logic [LVL_W-1:0] size, output logic glb);
    logic [PA_W-1:0]  a;
    logic [PTE_W-1:0] pte;
    logic [PPN_W-1:0] ppn;
    logic             done;
    logic             misal;
    a     = {root, vpn_slice(iova, 2), 3'b000};
    fault = 1'b0;
    cause = store ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    pa    = '0;
    size  = LVL_1G;
    glb   = 1'b0;
    done  = 1'b0;
    for (int lvl = 0; lvl < 3 && !done; lvl++) begin
        exp_addrs.push_back(a);
        size = LVL_W'(lvl);
        if (err_set.exists(a)) begin
            fault = 1'b1;
            cause = PT_DATA_CORRUPTION;
            done  = 1'b1;
        end else begin
            pte  = mem.exists(a) ? mem[a] : '0;
            ppn  = pte[53:10];
            glb  = glb | pte[5];
            done = 1'b1;
            // Superpages need the PPN bits they cover to be zero
            misal = (lvl == 0 && ppn[17:0] != 0) || (lvl == 1 && ppn[8:0] != 0);
            if (!pte[0] || (pte[2] && !pte[1]) || pte[63:54] != 0) begin
                fault = 1'b1;
            end else if (pte[1] || pte[3]) begin
                if (!pte[1] || !pte[6] || (store && !pte[7]) || misal) begin
                    fault = 1'b1;
                end else if (lvl == 0) begin
                    pa = {ppn[43:18], iova[29:0]};
                end else if (lvl == 1) begin
                    pa = {ppn[43:9], iova[20:0]};
                end else begin
                    pa = {ppn, iova[11:0]};
                end
            end else if (lvl == 2 || pte[6] || pte[7] || pte[4]) begin
                fault = 1'b1;
            end else begin
                a    = {ppn, vpn_slice(iova, 1 - lvl), 3'b000};
                done = 1'b0;
            end
        end
    end
endfunction

`endif

// ==== test/tb_ptw.sv ====
`timescale 1ns/1ps

module tb_ptw
    import ptw_pkg::*;
();

    localparam int NUM_DIRECTED = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_DLY      = 4;
    // Three accesses per walk at worst with each one stretched by the memory delay
    localparam int TIMEOUT = (NUM_DIRECTED + NUM_RANDOM) * 3 * (MAX_DLY + 6) + 100;

    localparam logic [7:0] F_V = 8'(1 << PTE_V);
    localparam logic [7:0] F_R = 8'(1 << PTE_R);
    localparam logic [7:0] F_W = 8'(1 << PTE_W_BIT);
    localparam logic [7:0] F_X = 8'(1 << PTE_X);
    localparam logic [7:0] F_U = 8'(1 << PTE_U);
    localparam logic [7:0] F_G = 8'(1 << PTE_G);
    localparam logic [7:0] F_A = 8'(1 << PTE_A);
    localparam logic [7:0] F_D = 8'(1 << PTE_D);
    localparam logic [7:0] F_RWAD = F_V | F_R | F_W | F_A | F_D;

    localparam logic [VA_W-1:0]  IOVA = 39'h3a_bcde_f123;
    localparam logic [PPN_W-1:0] ROOT = 44'h000_0008_0000;

    logic               clk_i;
    logic               rst_ni;
    logic               walk_req_i;
    logic               walk_ack_o;
    logic [VA_W-1:0]    iova_i;
    logic               is_store_i;
    logic [PPN_W-1:0]   root_ppn_i;
    logic               mem_req_o;
    logic [PA_W-1:0]    mem_addr_o;
    logic               mem_ack_i;
    logic [PTE_W-1:0]   mem_rdata_i;
    logic               mem_err_i;
    logic               fault_o;
    logic [CAUSE_W-1:0] cause_o;
    logic [PA_W-1:0]    paddr_o;
    logic [LVL_W-1:0]   page_size_o;
    logic               global_o;

    // Sparse page tables and the addresses that answer with an error
    logic [PTE_W-1:0] mem [logic [PA_W-1:0]];
    bit               err_set [logic [PA_W-1:0]];
    logic [PA_W-1:0]  ent_addr [3];
    logic [PA_W-1:0]  exp_addrs [$];

    logic [31:0]        lcg_state = 32'hcc2e_3e5c;
    logic               exp_fault;
    logic [CAUSE_W-1:0] exp_cause;
    logic [PA_W-1:0]    exp_paddr;
    logic [LVL_W-1:0]   exp_size;
    logic               exp_global;
    logic               result_checked;
    int                 cycles;

    `include "tb_ptw_ref.svh"

    ptw_top i_dut (.*);

    always #5 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Hang guard
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout: walks did not finish within %0d cycles", TIMEOUT);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // Memory model answering the PTE read handshake
    initial begin
        int dly;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        mem_err_i   = 1'b0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o && !mem_ack_i) begin
                dly = int'(lcg_next() % (MAX_DLY + 1));
                repeat (dly) @(negedge clk_i);
                if (exp_addrs.size() == 0) begin
                    report_failure("walker read memory after the expected last access");
                end else begin
                    check_val("mem_addr_o", 64'(mem_addr_o), 64'(exp_addrs.pop_front()));
                    mem_rdata_i = mem.exists(mem_addr_o) ? mem[mem_addr_o] : '0;
                    mem_err_i   = err_set.exists(mem_addr_o);
                    mem_ack_i   = 1'b1;
                    do @(negedge clk_i); while (mem_req_o);
                    mem_ack_i = 1'b0;
                    mem_err_i = 1'b0;
                end
            end
        end
    end

    // Comparison against the reference walk
    always @(negedge clk_i) begin
        if (walk_ack_o && !result_checked) begin
            if (exp_addrs.size() != 0) begin
                report_failure("walk finished before all expected memory accesses");
            end else begin
                check_val("fault_o", 64'(fault_o), 64'(exp_fault));
                if (exp_fault) begin
                    check_val("cause_o", 64'(cause_o), 64'(exp_cause));
                end else begin
                    check_val("paddr_o", 64'(paddr_o), 64'(exp_paddr));
                    check_val("page_size_o", 64'(page_size_o), 64'(exp_size));
                end
                check_val("global_o", 64'(global_o), 64'(exp_global));
                result_checked = 1'b1;
            end
        end
    end

    // One request from raise to release
    task automatic run_walk(input logic [VA_W-1:0] iova, input logic store,
                            input logic [PPN_W-1:0] root);
        int rel;
        exp_addrs.delete();
        ref_walk(iova, store, root, exp_fault, exp_cause, exp_paddr, exp_size, exp_global);
        result_checked = 1'b0;
        @(negedge clk_i);
        iova_i     = iova;
        is_store_i = store;
        root_ppn_i = root;
        walk_req_i = 1'b1;
        wait (result_checked);
        // Requester may sit on the result for a while
        rel = int'(lcg_next() % 4);
        repeat (rel) @(negedge clk_i);
        walk_req_i = 1'b0;
        do @(negedge clk_i); while (walk_ack_o);
    endtask

    task automatic random_walk();
        logic [VA_W-1:0]  iova;
        logic [PPN_W-1:0] root;
        logic [PPN_W-1:0] ppn;
        logic [7:0]       flags;
        int               lvl;
        iova  = {7'(lcg_next()), lcg_next()};
        root  = {12'(lcg_next()), lcg_next()};
        ppn   = {12'(lcg_next()), lcg_next()};
        lvl   = int'(lcg_next() % 3);
        flags = F_V | F_R | F_A | (8'(lcg_next()) & (F_W | F_X | F_G | F_D | F_U));
        // Occasional garbage flags
        if (lcg_next() % 6 == 0) begin
            flags = 8'(lcg_next());
        end
        if (lcg_next() % 4 != 0) begin
            if (lvl == 0) begin
                ppn[17:0] = '0;
            end
            if (lvl == 1) begin
                ppn[8:0] = '0;
            end
        end
        build_walk(iova, root, lvl, flags, ppn, lcg_next() % 2 == 0);
        if (lcg_next() % 12 == 0) begin
            err_set[ent_addr[lcg_next() % 3]] = 1'b1;
        end
        if (lcg_next() % 16 == 0) begin
            mem[ent_addr[lvl]][PTE_RSVD_LSB + int'(lcg_next() % 10)] = 1'b1;
        end
        run_walk(iova, lcg_next() % 2 == 1, root);
    endtask

    initial begin
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        walk_req_i     = 1'b0;
        iova_i         = '0;
        is_store_i     = 1'b0;
        root_ppn_i     = '0;
        result_checked = 1'b1;
        cycles         = 0;
        // Outputs stay quiet through reset and just after it
        for (int i = 0; i < 7; i++) begin
            @(negedge clk_i);
            if (i == 3) begin
                rst_ni = 1'b1;
            end
            check_val("walk_ack_o", 64'(walk_ack_o), 64'd0);
            check_val("mem_req_o", 64'(mem_req_o), 64'd0);
        end

        // Plain 4K walk followed by 1G and 2M leaves
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h123_4567_89ab, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 0, F_RWAD, 44'h000_0040_0000, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 1, F_RWAD, 44'h000_0040_0200, 1'b0);
        run_walk(IOVA, 1'b1, ROOT);

        // Misaligned superpages for load and store
        build_walk(IOVA, ROOT, 0, F_RWAD, 44'h000_0040_0200, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);
        run_walk(IOVA, 1'b1, ROOT);
        build_walk(IOVA, ROOT, 1, F_RWAD, 44'h000_0040_0001, 1'b0);
        run_walk(IOVA, 1'b1, ROOT);

        // Invalid, W without R, reserved bits
        build_walk(IOVA, ROOT, 2, 8'h00, 44'h5, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 2, F_V | F_W | F_A | F_D, 44'h5, 1'b0);
        run_walk(IOVA, 1'b1, ROOT);
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
        mem[ent_addr[2]][60] = 1'b1;
        run_walk(IOVA, 1'b0, ROOT);

        // Pointers with A, D or U set
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
        mem[ent_addr[0]][PTE_A] = 1'b1;
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
        mem[ent_addr[1]][PTE_D] = 1'b1;
        run_walk(IOVA, 1'b1, ROOT);
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
        mem[ent_addr[0]][PTE_U] = 1'b1;
        run_walk(IOVA, 1'b0, ROOT);

        // Pointer at the last level, store without D, leaf without A
        build_walk(IOVA, ROOT, 2, F_V, 44'h5, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 2, F_V | F_R | F_W | F_A, 44'h5, 1'b0);
        run_walk(IOVA, 1'b1, ROOT);
        build_walk(IOVA, ROOT, 2, F_V | F_R | F_D, 44'h5, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);

        // Memory error at each level stops the walk there
        for (int l = 0; l < 3; l++) begin
            build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
            err_set[ent_addr[l]] = 1'b1;
            run_walk(IOVA, 1'b0, ROOT);
        end

        // Global bit from a pointer and from a leaf
        build_walk(IOVA, ROOT, 2, F_RWAD, 44'h5, 1'b0);
        mem[ent_addr[0]][PTE_G] = 1'b1;
        run_walk(IOVA, 1'b0, ROOT);
        build_walk(IOVA, ROOT, 1, F_RWAD | F_G, 44'h200, 1'b0);
        run_walk(IOVA, 1'b0, ROOT);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_walk();
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+test
rtl/ptw_pkg.sv
rtl/pte_if.sv
rtl/pte_checker.sv
rtl/next_addr_gen.sv
rtl/walk_ctrl.sv
rtl/ptw_top.sv
test/tb_ptw.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ptw
FLIST     ?= flist.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= RESULT: PASS

SRCS := $(wildcard rtl/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(MDIR)/V$(TOP)

$(MDIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: compile
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(MDIR)
